/* rtl/clock_pkg.sv */
`default_nettype none

package clock_pkg;

    typedef logic [23:0] bcd_time_t; // hh mm ss, hour on top

    localparam logic [7:0]  HOUR_MAX         = 8'h23;
    localparam logic [7:0]  MINSEC_MAX       = 8'h59;
    localparam logic [7:0]  WORK_HOUR_MAX    = 8'h99;
    localparam logic [31:0] TICK_DIV_DEFAULT = 32'd100_000_000; // 1 s at 100 MHz

    // two-digit bcd increment, wraps to 00 after max
    function automatic logic [7:0] bcd_inc8(input logic [7:0] v, input logic [7:0] max);
        if (v == max)
            return 8'h00;
        if (v[3:0] == 4'h9)
            return {v[7:4] + 4'h1, 4'h0};
        return v + 8'h01;
    endfunction

    // one second forward, carries into min and hour
    function automatic bcd_time_t time_inc(input bcd_time_t t, input logic [7:0] hour_max);
        bcd_time_t r;
        r = t;
        r[7:0] = bcd_inc8(t[7:0], MINSEC_MAX);
        if (t[7:0] == MINSEC_MAX) begin
            r[15:8] = bcd_inc8(t[15:8], MINSEC_MAX);
            if (t[15:8] == MINSEC_MAX)
                r[23:16] = bcd_inc8(t[23:16], hour_max);
        end
        return r;
    endfunction

endpackage

`default_nettype wire

/* rtl/hood_pkg.sv */
`default_nettype none

package hood_pkg;

    typedef enum logic [3:0] {
        MODE_SHUTDOWN,
        MODE_STANDBY,
        MODE_MENU,
        MODE_ONE,
        MODE_TWO,
        MODE_STORM,
        MODE_CLEAN,
        MODE_SEARCH,
        MODE_SEARCH_WORK,
        MODE_SEARCH_REMIND,
        MODE_SET_HOUR,
        MODE_SET_MIN,
        MODE_SET_SEC
    } hood_mode_e;

    // low byte of the display word
    typedef enum logic [7:0] {
        TAG_WORK   = 8'd1,
        TAG_REMIND = 8'd3,
        TAG_STORM  = 8'd4,
        TAG_CLEAN  = 8'd5,
        TAG_NOW    = 8'd6
    } disp_tag_e;

    localparam logic [7:0]  STORM_LOAD   = 8'h60;   // bcd 60
    localparam logic [11:0] CLEAN_LOAD   = 12'h180; // bcd 180
    localparam logic [23:0] REMIND_RESET = 24'h100000;

endpackage

`default_nettype wire

/* rtl/hood_mode_fsm.sv */
`default_nettype none

module hood_mode_fsm import clock_pkg::*; import hood_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       key_a,
    input  logic       key_s,
    input  logic       key_d,
    input  logic       key_w,
    input  logic       key_x,
    input  logic       count_done,
    output hood_mode_e mode,
    output bcd_time_t  remind_time
);

    hood_mode_e mode_nxt;
    logic       armed;      // first key of a power sequence seen
    logic       arm_set;
    logic       storm_used;

    always_comb begin
        mode_nxt = mode;
        arm_set  = 1'b0;
        case (mode)
            MODE_SHUTDOWN: begin
                if (armed && key_d)
                    mode_nxt = MODE_STANDBY;
                else if (key_a)
                    arm_set = 1'b1;
            end
            MODE_STANDBY: begin
                if (armed && key_a)
                    mode_nxt = MODE_SHUTDOWN;
                else if (key_d)
                    arm_set = 1'b1;
                else if (key_w)
                    mode_nxt = MODE_MENU;
                else if (key_x)
                    mode_nxt = MODE_SEARCH;
            end
            MODE_MENU: begin
                if (key_a)
                    mode_nxt = MODE_ONE;
                else if (key_s)
                    mode_nxt = MODE_TWO;
                else if (key_d && !storm_used)
                    mode_nxt = MODE_STORM;
                else if (key_x)
                    mode_nxt = MODE_CLEAN;
            end
            MODE_ONE, MODE_TWO: begin
                if (key_s)
                    mode_nxt = MODE_TWO;
                else if (key_w)
                    mode_nxt = MODE_STANDBY;
            end
            MODE_STORM, MODE_CLEAN: begin
                if (count_done)
                    mode_nxt = MODE_STANDBY; // countdown over
            end
            MODE_SEARCH: begin
                if (key_a)
                    mode_nxt = MODE_SEARCH_WORK;
                else if (key_d)
                    mode_nxt = MODE_SEARCH_REMIND;
                else if (key_w)
                    mode_nxt = MODE_STANDBY;
            end
            MODE_SEARCH_WORK: begin
                if (key_w)
                    mode_nxt = MODE_SEARCH;
            end
            MODE_SEARCH_REMIND: begin
                if (key_w)
                    mode_nxt = MODE_SEARCH;
                else if (key_x)
                    mode_nxt = MODE_SET_HOUR;
            end
            MODE_SET_HOUR: if (key_s) mode_nxt = MODE_SET_MIN;
            MODE_SET_MIN:  if (key_s) mode_nxt = MODE_SET_SEC;
            MODE_SET_SEC:  if (key_s) mode_nxt = MODE_SEARCH_REMIND;
            default:       mode_nxt = MODE_STANDBY;
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            mode        <= MODE_STANDBY;
            armed       <= 1'b0;
            storm_used  <= 1'b0;
            remind_time <= REMIND_RESET;
        end else begin
            mode <= mode_nxt;
            if (mode_nxt != mode)
                armed <= 1'b0; // any mode change drops the arm
            else if (arm_set)
                armed <= 1'b1;

            if (mode == MODE_SHUTDOWN)
                storm_used <= 1'b0;
            else if (mode_nxt == MODE_STORM && mode != MODE_STORM)
                storm_used <= 1'b1;

            if (mode == MODE_SHUTDOWN) begin
                remind_time <= REMIND_RESET;
            end else if (key_a) begin
                case (mode)
                    MODE_SET_HOUR: remind_time[23:16] <= bcd_inc8(remind_time[23:16], HOUR_MAX);
                    MODE_SET_MIN:  remind_time[15:8]  <= bcd_inc8(remind_time[15:8], MINSEC_MAX);
                    MODE_SET_SEC:  remind_time[7:0]   <= bcd_inc8(remind_time[7:0], MINSEC_MAX);
                    default:       remind_time        <= remind_time;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/time_keeper.sv */
`default_nettype none

module time_keeper import clock_pkg::*; import hood_pkg::*; #(
    parameter logic [31:0] tick_div = TICK_DIV_DEFAULT
) (
    input  logic       clk,
    input  logic       rst,
    input  hood_mode_e mode,
    output logic       tick,
    output bcd_time_t  now_time,
    output bcd_time_t  work_time
);

    logic [31:0] div_cnt;
    logic        powered;
    logic        working;

    assign powered = (mode != MODE_SHUTDOWN);
    assign working = (mode == MODE_ONE) || (mode == MODE_TWO) || (mode == MODE_STORM);

    // prescaler, restarts while shut down
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            div_cnt <= '0;
            tick    <= 1'b0;
        end else if (!powered) begin
            div_cnt <= '0;
            tick    <= 1'b0;
        end else if (div_cnt == tick_div - 32'd1) begin
            div_cnt <= '0;
            tick    <= 1'b1;
        end else begin
            div_cnt <= div_cnt + 32'd1;
            tick    <= 1'b0;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            now_time  <= '0;
            work_time <= '0;
        end else if (!powered) begin
            now_time  <= '0;
            work_time <= '0;
        end else if (tick) begin
            now_time <= time_inc(now_time, HOUR_MAX); // rolls over after 23:59:59
            if (working)
                work_time <= time_inc(work_time, WORK_HOUR_MAX);
        end
    end

endmodule

`default_nettype wire

/* rtl/countdown_timer.sv */
`default_nettype none

module countdown_timer import hood_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  hood_mode_e  mode,
    input  logic        tick,
    output logic [11:0] count,
    output logic        count_done
);

    hood_mode_e prev_mode;
    logic       loaded;   // count holds a live countdown
    logic       timed;
    logic       entry;

    assign timed      = (mode == MODE_STORM) || (mode == MODE_CLEAN);
    assign entry      = timed && (mode != prev_mode);
    assign count_done = loaded && (count == 12'h000);

    // three-digit bcd decrement, caller keeps it above zero
    function automatic logic [11:0] bcd_dec12(input logic [11:0] v);
        if (v[3:0] != 4'h0)
            return {v[11:4], v[3:0] - 4'h1};
        if (v[7:4] != 4'h0)
            return {v[11:8], v[7:4] - 4'h1, 4'h9};
        return {v[11:8] - 4'h1, 8'h99};
    endfunction

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            prev_mode <= MODE_STANDBY;
            count     <= '0;
            loaded    <= 1'b0;
        end else begin
            prev_mode <= mode;
            if (entry) begin
                count  <= (mode == MODE_STORM) ? {4'h0, STORM_LOAD} : CLEAN_LOAD;
                loaded <= 1'b1;
            end else if (count_done || !timed) begin
                loaded <= 1'b0; // fsm leaves on this edge
            end else if (tick && count != 12'h000) begin
                count <= bcd_dec12(count);
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/display_select.sv */
`default_nettype none

module display_select import clock_pkg::*; import hood_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  hood_mode_e  mode,
    input  bcd_time_t   now_time,
    input  bcd_time_t   work_time,
    input  bcd_time_t   remind_time,
    input  logic [11:0] count,
    input  logic        light_dip,
    output logic [31:0] display_word,
    output logic        light_on
);

    logic powered_q;

    assign light_on = powered_q & light_dip;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            display_word <= {24'h0, TAG_NOW};
            powered_q    <= 1'b1; // reset lands in standby
        end else begin
            powered_q <= (mode != MODE_SHUTDOWN);
            case (mode)
                MODE_SEARCH_WORK:   display_word <= {work_time, TAG_WORK};
                MODE_SEARCH_REMIND,
                MODE_SET_HOUR,
                MODE_SET_MIN,
                MODE_SET_SEC:       display_word <= {remind_time, TAG_REMIND};
                MODE_STORM:         display_word <= {now_time, count[7:0]}; // remaining secs
                MODE_CLEAN:         display_word <= {20'h0, count};
                default:            display_word <= {now_time, TAG_NOW};
            endcase
        end
    end

endmodule

`default_nettype wire

/* rtl/hood_top.sv */
`default_nettype none

module hood_top import clock_pkg::*; import hood_pkg::*; #(
    parameter logic [31:0] tick_div = TICK_DIV_DEFAULT
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        key_a,
    input  logic        key_s,
    input  logic        key_d,
    input  logic        key_w,
    input  logic        key_x,
    input  logic        light_dip,
    output logic [31:0] display_word,
    output logic        light_on
);

    hood_mode_e  mode;
    bcd_time_t   remind_time;
    bcd_time_t   now_time;
    bcd_time_t   work_time;
    logic        tick;
    logic [11:0] count;
    logic        count_done;

    hood_mode_fsm u_hood_mode_fsm (
        .clk         (clk),
        .rst         (rst),
        .key_a       (key_a),
        .key_s       (key_s),
        .key_d       (key_d),
        .key_w       (key_w),
        .key_x       (key_x),
        .count_done  (count_done),
        .mode        (mode),
        .remind_time (remind_time)
    );

    time_keeper #(
        .tick_div (tick_div)
    ) u_time_keeper (
        .clk       (clk),
        .rst       (rst),
        .mode      (mode),
        .tick      (tick),
        .now_time  (now_time),
        .work_time (work_time)
    );

    countdown_timer u_countdown_timer (
        .clk        (clk),
        .rst        (rst),
        .mode       (mode),
        .tick       (tick),
        .count      (count),
        .count_done (count_done)
    );

    display_select u_display_select (
        .clk          (clk),
        .rst          (rst),
        .mode         (mode),
        .now_time     (now_time),
        .work_time    (work_time),
        .remind_time  (remind_time),
        .count        (count),
        .light_dip    (light_dip),
        .display_word (display_word),
        .light_on     (light_on)
    );

endmodule

`default_nettype wire

/* verification/hood_assertions.sv */
`default_nettype none

module hood_assertions import hood_pkg::*; (
    input logic        clk,
    input logic        rst,
    input hood_mode_e  mode,
    input logic [11:0] count,
    input logic        count_done,
    input logic        entry
);
    timeunit 1ns;
    timeprecision 100ps;

    // last legal encoding is the seconds setting
    mode_legal: assert property (@(posedge clk) disable iff (!rst) mode <= MODE_SET_SEC)
        else $error("mode holds an encoding outside the enum: %0d", mode);

    count_no_rise: assert property (@(posedge clk) disable iff (!rst)
        !entry |=> count <= $past(count))
        else $error("countdown value rose without a load");

    done_to_standby: assert property (@(posedge clk) disable iff (!rst)
        count_done |=> mode == MODE_STANDBY)
        else $error("countdown ended but mode did not return to standby");

endmodule

`default_nettype wire

/* verification/hood_checker.sv */
`default_nettype none

module hood_checker (
    input  logic        clk,
    input  logic        check_en,
    input  logic [31:0] exp_word,
    input  logic        exp_light,
    input  logic [31:0] display_word,
    input  logic        light_on,
    output int          mismatches,
    output int          checks_done
);
    timeunit 1ns;
    timeprecision 100ps;

    int err_count = 0;
    int check_count = 0;

    assign mismatches  = err_count;
    assign checks_done = check_count;

    // dut outputs here still hold the values from the last edge
    always @(posedge clk) begin
        if (check_en) begin
            check_count = check_count + 1;
            if (display_word !== exp_word || light_on !== exp_light) begin
                err_count = err_count + 1;
                $display("ERR %0d ns: check %0d expected display %h light %b, got display %h light %b",
                         $time, check_count, exp_word, exp_light, display_word, light_on);
            end
        end
    end

endmodule

`default_nettype wire

/* verification/hood_tb.sv */
`default_nettype none

module hood_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_RECORDS  = 29;
    localparam int MAX_RECORDS  = 64;
    localparam int RESET_CYCLES = 8;

    logic        clk;
    logic        rst;
    logic        key_a;
    logic        key_s;
    logic        key_d;
    logic        key_w;
    logic        key_x;
    logic        light_dip;
    logic [31:0] display_word;
    logic        light_on;

    logic        check_en;
    logic [31:0] exp_word;
    logic        exp_light;
    int          mismatches;
    int          checks_done;

    logic [7:0]  rec_key   [MAX_RECORDS]; // 0 for no key
    int          rec_reps  [MAX_RECORDS];
    logic        rec_light [MAX_RECORDS];
    int          rec_wait  [MAX_RECORDS];
    logic [31:0] rec_word  [MAX_RECORDS];
    logic        rec_lexp  [MAX_RECORDS];
    int          rec_count;
    int          file_errors;
    int          cycle_count;
    int          cycle_limit;

    hood_top #(
        .tick_div (32'd4)
    ) u_hood_top (
        .clk          (clk),
        .rst          (rst),
        .key_a        (key_a),
        .key_s        (key_s),
        .key_d        (key_d),
        .key_w        (key_w),
        .key_x        (key_x),
        .light_dip    (light_dip),
        .display_word (display_word),
        .light_on     (light_on)
    );

    hood_checker u_hood_checker (
        .clk          (clk),
        .check_en     (check_en),
        .exp_word     (exp_word),
        .exp_light    (exp_light),
        .display_word (display_word),
        .light_on     (light_on),
        .mismatches   (mismatches),
        .checks_done  (checks_done)
    );

    bind countdown_timer hood_assertions u_hood_assertions (
        .clk        (clk),
        .rst        (rst),
        .mode       (mode),
        .count      (count),
        .count_done (count_done),
        .entry      (entry)
    );

    always #5 clk = ~clk;

    // run limit comes from the record waits
    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            $display("*** FAILED ***");
            $finish;
        end
    end

    task automatic press_key(input logic [7:0] key);
        key_a = (key == "a");
        key_s = (key == "s");
        key_d = (key == "d");
        key_w = (key == "w");
        key_x = (key == "x");
    endtask

    task automatic load_stimulus();
        int          fd;
        int          n;
        string       line;
        logic [31:0] key_tok;
        int          reps;
        int          light;
        int          wait_cycles;
        logic [31:0] word;
        int          lexp;
        fd = $fopen("verification/hood_input.txt", "r");
        if (fd == 0) begin
            $display("could not open the input file verification/hood_input.txt");
            file_errors++;
            return;
        end
        while (!$feof(fd) && rec_count < MAX_RECORDS) begin
            line = "";
            n = $fgets(line, fd);
            if (n > 0 && line.getc(0) != "#") begin
                n = $sscanf(line, "%s %d %d %d %h %d",
                            key_tok, reps, light, wait_cycles, word, lexp);
                if (n == 6 && (key_tok == "none" || (key_tok[31:8] == 24'h0 &&
                    key_tok[7:0] inside {"a", "s", "d", "w", "x"}))) begin
                    rec_key[rec_count]   = (key_tok == "none") ? 8'h00 : key_tok[7:0];
                    rec_reps[rec_count]  = reps;
                    rec_light[rec_count] = (light != 0);
                    rec_wait[rec_count]  = wait_cycles;
                    rec_word[rec_count]  = word;
                    rec_lexp[rec_count]  = (lexp != 0);
                    rec_count++;
                end else if (n > 0) begin
                    $display("input file has a line that cannot be read: %s", line);
                    file_errors++;
                end
            end
        end
        $fclose(fd);
        if (rec_count < NUM_RECORDS) begin
            $display("input file is short, %0d of %0d records", rec_count, NUM_RECORDS);
            file_errors++;
        end
    endtask

    // presses one cycle apart, then the wait, then one check cycle
    task automatic apply_record(input int idx);
        int r;
        light_dip = rec_light[idx];
        for (r = 0; r < rec_reps[idx]; r++) begin
            press_key(rec_key[idx]);
            @(negedge clk);
            press_key(8'h00);
            @(negedge clk);
        end
        repeat (rec_wait[idx]) @(negedge clk);
        exp_word  = rec_word[idx];
        exp_light = rec_lexp[idx];
        check_en  = 1'b1;
        @(negedge clk);
        check_en  = 1'b0;
    endtask

    initial begin
        int i;
        clk         = 1'b0;
        rst         = 1'b0;
        light_dip   = 1'b0;
        check_en    = 1'b0;
        exp_word    = '0;
        exp_light   = 1'b0;
        rec_count   = 0;
        file_errors = 0;
        cycle_count = 0;
        cycle_limit = RESET_CYCLES + 200;
        press_key(8'h00);

        load_stimulus();
        for (i = 0; i < rec_count; i++)
            cycle_limit = cycle_limit + 2 * rec_reps[i] + rec_wait[i] + 1;

        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b1;

        for (i = 0; i < rec_count; i++)
            apply_record(i);

        $display("checks %0d, mismatches %0d, file errors %0d",
                 checks_done, mismatches, file_errors);
        if (mismatches == 0 && file_errors == 0 && checks_done == rec_count)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

/* verification/hood_input.txt */
# key reps light_dip wait expected_display(hex) expected_light_on
# key is a, s, d, w, x or none; reps presses one cycle apart, then wait cycles, then check
none 0 1 2 00000006 1
none 0 0 41 00001006 0
none 0 1 199 00010006 1
x 1 1 2 00010106 1
d 1 1 2 10000003 1
x 1 1 1 10000003 1
a 14 1 2 00000003 1
s 1 1 1 00000003 1
a 60 1 2 00000003 1
s 2 1 2 00000003 1
w 2 1 2 00014706 1
w 1 1 1 00014806 1
d 1 1 6 00015059 1
none 0 1 248 00025206 1
w 1 1 1 00025306 1
d 1 1 2 00025406 1
x 1 1 1 00000180 1
none 0 1 10 00000177 1
none 0 1 720 00055806 1
x 1 1 1 00055906 1
a 1 1 2 00010101 1
w 2 1 2 00060206 1
d 1 1 1 00060306 1
a 1 1 8 00000006 0
w 1 1 40 00000006 0
a 1 1 1 00000006 0
d 1 1 26 00000606 1
w 1 1 1 00000706 1
d 1 1 6 00000959 1

/* list.f */
rtl/clock_pkg.sv
rtl/hood_pkg.sv
rtl/hood_mode_fsm.sv
rtl/time_keeper.sv
rtl/countdown_timer.sv
rtl/display_select.sv
rtl/hood_top.sv
verification/hood_assertions.sv
verification/hood_checker.sv
verification/hood_tb.sv

/* run_sim.sh */
#!/bin/sh
# verilator build and run of the range hood testbench

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps -Wno-fatal \
    --top-module hood_tb -f list.f -o hood_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "verilator build failed"
    exit 1
fi

./obj_dir/hood_sim > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -q -F '*** PASSED ***' sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1
